// File: Bender.yml
package:
  name: debug_readout

sources:
  # Packages first, then leaf modules, then the top level
  - hdl/stage_pkg.sv
  - hdl/debug_pkg.sv
  - hdl/snapshot_latch.sv
  - hdl/regfile_walker.sv
  - hdl/frame_arbiter.sv
  - hdl/debug_readout.sv

  - target: test
    files:
      - dv/debug_readout_tb.sv

// File: build.f
hdl/stage_pkg.sv
hdl/debug_pkg.sv
hdl/snapshot_latch.sv
hdl/regfile_walker.sv
hdl/frame_arbiter.sv
hdl/debug_readout.sv
dv/debug_readout_tb.sv

// File: dv/debug_readout_tb.sv
`timescale 1ns/1ps

module debug_readout_tb;

   localparam int clock_period   = 40;
   localparam int table_rows     = 10;
   localparam int timeout_cycles = table_rows * 40 + 100;

   logic                              i_clock;
   logic                              reset;
   logic                              i_request_valid;
   logic [debug_pkg::nb_ctrl_id-1:0]  i_request_id;
   stage_pkg::fetch_data_t            i_fetch_data;
   stage_pkg::fetch_control_t         i_fetch_control;
   stage_pkg::decode_data_t           i_decode_data;
   stage_pkg::exec_data_t             i_exec_data;
   logic [stage_pkg::nb_reg-1:0]      i_regfile_data;
   logic [stage_pkg::nb_reg_addr-1:0] o_regfile_addr;
   logic [debug_pkg::nb_frame-1:0]    o_frame;
   logic                              o_frame_valid;
   logic                              o_end_of_data;

   logic [31:0] regfile_model [stage_pkg::regfile_depth];
   logic [31:0] lcg_state;
   int          errors;
   int          checks;
   int          rows_loaded;

   // Request table with ID, acceptance and frame count per row
   logic [debug_pkg::nb_ctrl_id-1:0] row_id     [table_rows];
   logic                             row_accept [table_rows];
   int                               row_frames [table_rows];

   debug_readout debug_readout_inst (
      .i_clock         (i_clock),
      .reset           (reset),
      .i_request_valid (i_request_valid),
      .i_request_id    (i_request_id),
      .i_fetch_data    (i_fetch_data),
      .i_fetch_control (i_fetch_control),
      .i_decode_data   (i_decode_data),
      .i_exec_data     (i_exec_data),
      .i_regfile_data  (i_regfile_data),
      .o_regfile_addr  (o_regfile_addr),
      .o_frame         (o_frame),
      .o_frame_valid   (o_frame_valid),
      .o_end_of_data   (o_end_of_data)
   );

   // Register file answers in the same cycle
   assign i_regfile_data = regfile_model[o_regfile_addr];

   always #(clock_period / 2) i_clock = ~i_clock;

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic add_row(input logic [debug_pkg::nb_ctrl_id-1:0] id, input logic accept,
                          input int frames);
      row_id[rows_loaded]     = id;
      row_accept[rows_loaded] = accept;
      row_frames[rows_loaded] = frames;
      rows_loaded++;
   endtask

   task automatic new_snapshots();
      stage_pkg::fetch_data_t    fd;
      stage_pkg::fetch_control_t fc;
      stage_pkg::decode_data_t   dd;
      stage_pkg::exec_data_t     ed;
      fd.instruction = next_random();
      fc.system_pc   = next_random();
      fc.pc          = next_random();
      dd.shamt       = 5'(next_random());
      dd.a           = next_random();
      dd.b           = next_random();
      dd.inm         = 16'(next_random());
      ed.alu         = next_random();
      ed.b           = next_random();
      i_fetch_data    <= fd;
      i_fetch_control <= fc;
      i_decode_data   <= dd;
      i_exec_data     <= ed;
   endtask

   // Payload laid out LSB first and zero padded to three frames
   function automatic logic [95:0] captured_payload(input logic [debug_pkg::nb_ctrl_id-1:0] id);
      case (id)
         debug_pkg::id_fetch_data:
            return {64'd0, i_fetch_data.instruction};
         debug_pkg::id_fetch_control:
            return {32'd0, i_fetch_control.system_pc, i_fetch_control.pc};
         debug_pkg::id_decode_data:
            return {11'd0, i_decode_data.shamt, i_decode_data.a, i_decode_data.b,
                    i_decode_data.inm};
         debug_pkg::id_exec_data:
            return {32'd0, i_exec_data.alu, i_exec_data.b};
         default:
            return '0;
      endcase
   endfunction

   task automatic check_idle(input int n_cycles);
      repeat (n_cycles) begin
         @(negedge i_clock);
         check(o_frame_valid, 0, "frame valid while idle");
         check(o_end_of_data, 0, "end of data while idle");
         check(32'(o_regfile_addr), 0, "register address while idle");
         @(posedge i_clock);
      end
   endtask

   task automatic run_readout(input logic [debug_pkg::nb_ctrl_id-1:0] id, input int n_frames);
      logic [95:0]                      payload;
      logic [31:0]                      expected;
      logic [debug_pkg::nb_ctrl_id-1:0] intruder;
      intruder = (id == debug_pkg::id_regfile) ? debug_pkg::id_exec_data : debug_pkg::id_regfile;
      @(posedge i_clock);
      i_request_valid <= 1'b1;
      i_request_id    <= id;
      @(posedge i_clock);
      // Snapshots move on right after the capture edge
      payload = captured_payload(id);
      new_snapshots();
      // Strobe held into the first frame cycle with another ID
      i_request_id <= intruder;
      for (int k = 0; k < n_frames; k++) begin
         @(negedge i_clock);
         if (id == debug_pkg::id_regfile) begin
            expected = regfile_model[k];
            check(32'(o_regfile_addr), k, "register address");
         end else begin
            expected = payload[32*k +: 32];
         end
         check(o_frame_valid, 1, "frame valid during readout");
         check(o_end_of_data, 0, "end of data during readout");
         check(o_frame, expected, "frame data");
         @(posedge i_clock);
         // Strobe again in the end of data cycle
         i_request_valid <= (k == n_frames - 1);
      end
      @(negedge i_clock);
      check(o_frame_valid, 0, "frame valid after last frame");
      check(o_end_of_data, 1, "end of data pulse");
      @(posedge i_clock);
      i_request_valid <= 1'b0;
      check_idle(2);
   endtask

   task automatic run_ignored(input logic [debug_pkg::nb_ctrl_id-1:0] id);
      @(posedge i_clock);
      i_request_valid <= 1'b1;
      i_request_id    <= id;
      @(posedge i_clock);
      i_request_valid <= 1'b0;
      check_idle(4);
   endtask

   initial begin
      i_clock         = 1'b0;
      reset           = 1'b1;
      i_request_valid = 1'b0;
      i_request_id    = '0;
      errors          = 0;
      checks          = 0;
      rows_loaded     = 0;
      lcg_state       = 32'hdcb520dc;
      for (int i = 0; i < stage_pkg::regfile_depth; i++) begin
         regfile_model[i] = next_random();
      end
      new_snapshots();

      add_row(debug_pkg::id_fetch_data,    1'b1, 1);
      add_row(debug_pkg::id_fetch_control, 1'b1, 2);
      add_row(debug_pkg::id_decode_data,   1'b1, 3);
      add_row(debug_pkg::id_exec_data,     1'b1, 2);
      add_row(debug_pkg::id_regfile,       1'b1, 32);
      add_row(6'b111111,                   1'b0, 0);
      add_row(debug_pkg::id_decode_data,   1'b1, 3);
      add_row(6'b100111,                   1'b0, 0);
      add_row(debug_pkg::id_regfile,       1'b1, 32);
      add_row(debug_pkg::id_fetch_data,    1'b1, 1);

      repeat (8) @(posedge i_clock);
      reset <= 1'b0;
      check_idle(2);

      for (int r = 0; r < rows_loaded; r++) begin
         if (row_accept[r]) begin
            run_readout(row_id[r], row_frames[r]);
         end else begin
            run_ignored(row_id[r]);
         end
      end

      $display("Run complete: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(timeout_cycles * clock_period);
      $display("Timeout: the readout sequence did not finish within %0d cycles", timeout_cycles);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: hdl/debug_pkg.sv
package debug_pkg;

   // Frame and request widths
   localparam int nb_frame   = 32;
   localparam int nb_ctrl_id = 6;

   // Controller IDs as seen by the host
   localparam logic [nb_ctrl_id-1:0] id_fetch_data    = 6'b100100;
   localparam logic [nb_ctrl_id-1:0] id_fetch_control = 6'b100101;
   localparam logic [nb_ctrl_id-1:0] id_decode_data   = 6'b100110;
   localparam logic [nb_ctrl_id-1:0] id_exec_data     = 6'b101000;
   localparam logic [nb_ctrl_id-1:0] id_regfile       = 6'b000000;

   // Four stage snapshots plus the register file
   localparam int n_controllers = 5;

endpackage

// File: hdl/debug_readout.sv
`timescale 1ns/1ps

module debug_readout (
   input  logic                              i_clock,
   input  logic                              reset,
   input  logic                              i_request_valid,
   input  logic [debug_pkg::nb_ctrl_id-1:0]  i_request_id,
   input  stage_pkg::fetch_data_t            i_fetch_data,
   input  stage_pkg::fetch_control_t         i_fetch_control,
   input  stage_pkg::decode_data_t           i_decode_data,
   input  stage_pkg::exec_data_t             i_exec_data,
   input  logic [stage_pkg::nb_reg-1:0]      i_regfile_data,
   output logic [stage_pkg::nb_reg_addr-1:0] o_regfile_addr,
   output logic [debug_pkg::nb_frame-1:0]    o_frame,
   output logic                              o_frame_valid,
   output logic                              o_end_of_data
);

   logic [debug_pkg::n_controllers-1:0][debug_pkg::nb_frame-1:0] frames;
   logic [debug_pkg::n_controllers-1:0]                          writing;
   logic                                                         request_fire;

   // Requests are dropped while a readout runs or just ended
   assign request_fire = i_request_valid & ~o_frame_valid & ~o_end_of_data;

   snapshot_latch #(
      .payload_t     (stage_pkg::fetch_data_t),
      .controller_id (debug_pkg::id_fetch_data)
   ) u_fetch_data (
      .i_clock        (i_clock),
      .reset          (reset),
      .i_request_fire (request_fire),
      .i_request_id   (i_request_id),
      .i_payload      (i_fetch_data),
      .o_frame        (frames[0]),
      .o_writing      (writing[0])
   );

   snapshot_latch #(
      .payload_t     (stage_pkg::fetch_control_t),
      .controller_id (debug_pkg::id_fetch_control)
   ) u_fetch_control (
      .i_clock        (i_clock),
      .reset          (reset),
      .i_request_fire (request_fire),
      .i_request_id   (i_request_id),
      .i_payload      (i_fetch_control),
      .o_frame        (frames[1]),
      .o_writing      (writing[1])
   );

   snapshot_latch #(
      .payload_t     (stage_pkg::decode_data_t),
      .controller_id (debug_pkg::id_decode_data)
   ) u_decode_data (
      .i_clock        (i_clock),
      .reset          (reset),
      .i_request_fire (request_fire),
      .i_request_id   (i_request_id),
      .i_payload      (i_decode_data),
      .o_frame        (frames[2]),
      .o_writing      (writing[2])
   );

   snapshot_latch #(
      .payload_t     (stage_pkg::exec_data_t),
      .controller_id (debug_pkg::id_exec_data)
   ) u_exec_data (
      .i_clock        (i_clock),
      .reset          (reset),
      .i_request_fire (request_fire),
      .i_request_id   (i_request_id),
      .i_payload      (i_exec_data),
      .o_frame        (frames[3]),
      .o_writing      (writing[3])
   );

   regfile_walker #(
      .controller_id (debug_pkg::id_regfile)
   ) u_regfile (
      .i_clock        (i_clock),
      .reset          (reset),
      .i_request_fire (request_fire),
      .i_request_id   (i_request_id),
      .i_regfile_data (i_regfile_data),
      .o_regfile_addr (o_regfile_addr),
      .o_frame        (frames[4]),
      .o_writing      (writing[4])
   );

   frame_arbiter u_frame_arbiter (
      .i_clock       (i_clock),
      .reset         (reset),
      .i_frames      (frames),
      .i_writing     (writing),
      .o_frame       (o_frame),
      .o_frame_valid (o_frame_valid),
      .o_end_of_data (o_end_of_data)
   );

endmodule

// File: hdl/frame_arbiter.sv
`timescale 1ns/1ps

module frame_arbiter (
   input  logic                                                  i_clock,
   input  logic                                                  reset,
   input  logic [debug_pkg::n_controllers-1:0][debug_pkg::nb_frame-1:0] i_frames,
   input  logic [debug_pkg::n_controllers-1:0]                   i_writing,
   output logic [debug_pkg::nb_frame-1:0]                        o_frame,
   output logic                                                  o_frame_valid,
   output logic                                                  o_end_of_data
);

   logic any_writing;
   logic any_writing_d;

   // Pass a frame only when exactly one controller writes
   always_comb begin
      o_frame = '0;
      if ($onehot(i_writing)) begin
         for (int i = 0; i < debug_pkg::n_controllers; i++) begin
            if (i_writing[i]) begin
               o_frame = i_frames[i];
            end
         end
      end
   end

   assign any_writing = |i_writing;

   always_ff @(posedge i_clock) begin
      if (reset) begin
         any_writing_d <= 1'b0;
      end else begin
         any_writing_d <= any_writing;
      end
   end

   assign o_frame_valid = any_writing;
   // Falling edge of the writing OR
   assign o_end_of_data = any_writing_d & ~any_writing;

endmodule

// File: hdl/regfile_walker.sv
`timescale 1ns/1ps

module regfile_walker #(
   parameter logic [debug_pkg::nb_ctrl_id-1:0] controller_id = '0
) (
   input  logic                             i_clock,
   input  logic                             reset,
   input  logic                             i_request_fire,
   input  logic [debug_pkg::nb_ctrl_id-1:0] i_request_id,
   input  logic [stage_pkg::nb_reg-1:0]     i_regfile_data,
   output logic [stage_pkg::nb_reg_addr-1:0] o_regfile_addr,
   output logic [debug_pkg::nb_frame-1:0]   o_frame,
   output logic                             o_writing
);

   localparam logic [stage_pkg::nb_reg_addr-1:0] last_addr =
      stage_pkg::nb_reg_addr'(stage_pkg::regfile_depth - 1);

   logic [stage_pkg::nb_reg_addr-1:0] addr;
   logic                              active;
   logic                              request_hit;

   assign request_hit = i_request_fire && (i_request_id == controller_id);

   // One register per cycle, address parks at 0 when done
   always_ff @(posedge i_clock) begin
      if (reset) begin
         active <= 1'b0;
         addr   <= '0;
      end else if (request_hit) begin
         active <= 1'b1;
         addr   <= '0;
      end else if (active) begin
         if (addr == last_addr) begin
            active <= 1'b0;
            addr   <= '0;
         end else begin
            addr <= addr + 1'b1;
         end
      end
   end

   assign o_regfile_addr = addr;
   // Read data comes back in the same cycle
   assign o_frame        = i_regfile_data;
   assign o_writing      = active;

endmodule

// File: hdl/snapshot_latch.sv
`timescale 1ns/1ps

module snapshot_latch #(
   parameter type payload_t = logic [31:0],
   parameter logic [debug_pkg::nb_ctrl_id-1:0] controller_id = '0
) (
   input  logic                            i_clock,
   input  logic                            reset,
   input  logic                            i_request_fire,
   input  logic [debug_pkg::nb_ctrl_id-1:0] i_request_id,
   input  payload_t                        i_payload,
   output logic [debug_pkg::nb_frame-1:0]  o_frame,
   output logic                            o_writing
);

   localparam int nb_payload = $bits(payload_t);
   localparam int n_words    = (nb_payload + debug_pkg::nb_frame - 1) / debug_pkg::nb_frame;
   localparam int nb_buffer  = n_words * debug_pkg::nb_frame;
   localparam int nb_count   = $clog2(n_words + 1);

   logic [nb_buffer-1:0] buffer;
   logic [nb_count-1:0]  words_left;
   logic                 request_hit;

   // Busy check is done once at the top
   assign request_hit = i_request_fire && (i_request_id == controller_id);

   // Frames still to send, zero when idle
   always_ff @(posedge i_clock) begin
      if (reset) begin
         words_left <= '0;
      end else if (request_hit) begin
         words_left <= nb_count'(n_words);
      end else if (words_left != '0) begin
         words_left <= words_left - 1'b1;
      end
   end

   // Snapshot taken at the request edge, upper bits zero
   always_ff @(posedge i_clock) begin
      if (request_hit) begin
         buffer <= nb_buffer'(i_payload);
      end else if (words_left != '0) begin
         buffer <= buffer >> debug_pkg::nb_frame;
      end
   end

   // Least significant word goes out first
   assign o_frame   = buffer[debug_pkg::nb_frame-1:0];
   assign o_writing = (words_left != '0);

endmodule

// File: hdl/stage_pkg.sv
package stage_pkg;

   // Register file geometry
   localparam int nb_reg        = 32;
   localparam int nb_reg_addr   = 5;
   localparam int regfile_depth = 32;

   // Instruction field widths
   localparam int nb_shamt = 5;
   localparam int nb_inm   = 16;

   // IR out of fetch
   typedef struct packed {
      logic [nb_reg-1:0] instruction;
   } fetch_data_t;

   typedef struct packed {
      logic [nb_reg-1:0] system_pc;
      logic [nb_reg-1:0] pc;
   } fetch_control_t;

   // 85 bits, last frame gets padded
   typedef struct packed {
      logic [nb_shamt-1:0] shamt;
      logic [nb_reg-1:0]   a;
      logic [nb_reg-1:0]   b;
      logic [nb_inm-1:0]   inm;
   } decode_data_t;

   typedef struct packed {
      logic [nb_reg-1:0] alu;
      logic [nb_reg-1:0] b;
   } exec_data_t;

endpackage
